// File: include/rv_opcodes.svh
/* opcode, funct and field position macros for the rv64 integer subset
   included by the decoder and by the testbench when it assembles programs */
`ifndef rv_opcodes_svh
`define rv_opcodes_svh

// major opcodes found in inst[6:0]
`define op_imm      7'b0010011
`define op_op       7'b0110011
`define op_auipc    7'b0010111
`define op_jal      7'b1101111
`define op_jalr     7'b1100111
`define op_store    7'b0100011
`define op_load     7'b0000011
`define op_system   7'b1110011

`define f3_add_sub  3'b000  // addi, add and sub share this one
`define f3_slt      3'b010
`define f3_double   3'b011  // doubleword width for sd and ld
`define f3_jalr     3'b000
`define f3_priv     3'b000
`define f7_base     7'b0000000
`define f7_alt      7'b0100000  // selects sub over add
`define f12_ebreak  12'h001

// bit ranges of the instruction fields
`define opcode_bits  6:0
`define rd_bits      11:7
`define funct3_bits  14:12
`define rs1_bits     19:15
`define rs2_bits     24:20
`define funct7_bits  31:25
`define funct12_bits 31:20

`endif

// File: rtl/decoder.sv
/* combinational decoder for the kept rv64 subset, producing register indices,
   the sign extended immediate, the alu operation and the control flags */
`default_nettype none
`timescale 1ns/1ps

`include "rv_opcodes.svh"

module decoder (
  input  logic [rv_pkg::inst_width-1:0]   inst,
  output logic [rv_pkg::reg_id_width-1:0] rd,
  output logic [rv_pkg::reg_id_width-1:0] rs1,
  output logic [rv_pkg::reg_id_width-1:0] rs2,
  output logic [rv_pkg::xlen-1:0]         imm,
  output logic                            need_imm,
  output rv_pkg::alu_op_t                 alu_op,
  output logic                            is_auipc,
  output logic                            is_jal,
  output logic                            is_jalr,
  output logic                            is_store,
  output logic                            is_ebreak,
  output logic                            is_nop,
  output logic                            reg_wen,
  output logic                            inst_not_impl
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] funct12;

  logic addi, slti, add, sub, sd;

  logic [rv_pkg::xlen-1:0] imm_i;
  logic [rv_pkg::xlen-1:0] imm_s;
  logic [rv_pkg::xlen-1:0] imm_u;
  logic [rv_pkg::xlen-1:0] imm_j;

  assign opcode  = inst[`opcode_bits];
  assign funct3  = inst[`funct3_bits];
  assign funct7  = inst[`funct7_bits];
  assign funct12 = inst[`funct12_bits];

  assign rd  = inst[`rd_bits];
  assign rs1 = inst[`rs1_bits];
  assign rs2 = inst[`rs2_bits];

  // each kept instruction is one match on opcode and its funct fields
  assign addi      = (opcode == `op_imm) && (funct3 == `f3_add_sub);
  assign slti      = (opcode == `op_imm) && (funct3 == `f3_slt);
  assign add       = (opcode == `op_op) && (funct3 == `f3_add_sub) && (funct7 == `f7_base);
  assign sub       = (opcode == `op_op) && (funct3 == `f3_add_sub) && (funct7 == `f7_alt);
  assign sd        = (opcode == `op_store) && (funct3 == `f3_double);
  assign is_auipc  = (opcode == `op_auipc);
  assign is_jal    = (opcode == `op_jal);
  assign is_jalr   = (opcode == `op_jalr) && (funct3 == `f3_jalr);
  assign is_ebreak = (opcode == `op_system) && (funct3 == `f3_priv) && (funct12 == `f12_ebreak);
  assign is_nop    = (inst == '0);  // the all zero word retires with no effect
  assign is_store  = sd;

  // immediates are always sign extended from inst[31]
  assign imm_i = {{52{inst[31]}}, inst[`funct12_bits]};
  assign imm_s = {{52{inst[31]}}, inst[`funct7_bits], inst[`rd_bits]};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    if (addi || slti || is_jalr)
      imm = imm_i;
    else if (sd)
      imm = imm_s;
    else if (is_auipc)
      imm = imm_u;
    else if (is_jal)
      imm = imm_j;
    else
      imm = '0;  // register forms carry no immediate
  end

  // operand b comes from the immediate for every type except the r form
  assign need_imm = addi || slti || is_auipc || is_jalr || sd;

  always_comb begin
    if (addi || add || is_auipc || is_jalr || sd)
      alu_op = rv_pkg::alu_add;  // jalr target and store address use the adder
    else if (sub)
      alu_op = rv_pkg::alu_sub;
    else if (slti)
      alu_op = rv_pkg::alu_lt;
    else
      alu_op = rv_pkg::alu_none;
  end

  assign reg_wen = addi || slti || add || sub || is_auipc || is_jal || is_jalr;

  // anything else halts the slice, ld included since there is no data port
  assign inst_not_impl = !(addi || slti || add || sub || sd || is_auipc ||
                           is_jal || is_jalr || is_ebreak || is_nop);

endmodule

`default_nettype wire

// File: rtl/exec_unit.sv
/* execute unit that pops one queue entry per cycle, runs it against the
   register file and reports commit, store, redirect and halt */
`default_nettype none
`timescale 1ns/1ps

module exec_unit (
  input  logic                            clk,
  input  logic                            rst_n,
  input  rv_pkg::queue_entry_t            head_entry,
  input  logic                            empty,
  output logic                            pop,
  output logic                            redirect_valid,
  output logic [rv_pkg::xlen-1:0]         redirect_pc,
  output logic                            commit_valid,
  output logic [rv_pkg::xlen-1:0]         commit_pc,
  output logic                            commit_reg_wen,
  output logic [rv_pkg::reg_id_width-1:0] commit_rd,
  output logic [rv_pkg::xlen-1:0]         commit_wdata,
  output logic                            store_valid,
  output logic [rv_pkg::xlen-1:0]         store_addr,
  output logic [rv_pkg::xlen-1:0]         store_data,
  output logic [7:0]                      store_wmask,
  output logic                            halted,
  output logic                            illegal
);

  logic [rv_pkg::reg_id_width-1:0] rd, rs1, rs2;
  logic [rv_pkg::xlen-1:0]         imm;
  logic                            need_imm;
  rv_pkg::alu_op_t                 alu_op;
  logic is_auipc, is_jal, is_jalr, is_store, is_ebreak, reg_wen, inst_not_impl;

  logic [rv_pkg::xlen-1:0] regs [32];
  logic [rv_pkg::xlen-1:0] rs1_val, rs2_val;
  logic [rv_pkg::xlen-1:0] op_a, op_b, alu_res, link, wdata;

  decoder i_decoder (
    .inst          (head_entry.inst),
    .rd            (rd),
    .rs1           (rs1),
    .rs2           (rs2),
    .imm           (imm),
    .need_imm      (need_imm),
    .alu_op        (alu_op),
    .is_auipc      (is_auipc),
    .is_jal        (is_jal),
    .is_jalr       (is_jalr),
    .is_store      (is_store),
    .is_ebreak     (is_ebreak),
    .is_nop        (),  // the zero word already has reg_wen low
    .reg_wen       (reg_wen),
    .inst_not_impl (inst_not_impl)
  );

  assign pop = !empty && !halted;  // never stalls short of a halt

  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];  // x0 is hardwired to zero
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

  assign op_a = is_auipc ? head_entry.pc : rs1_val;
  assign op_b = need_imm ? imm : rs2_val;

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add: alu_res = op_a + op_b;
      rv_pkg::alu_sub: alu_res = op_a - op_b;
      rv_pkg::alu_lt:  alu_res = {63'b0, $signed(op_a) < $signed(op_b)};
      default:         alu_res = '0;
    endcase
  end

  assign link  = head_entry.pc + 'd4;
  assign wdata = (is_jal || is_jalr) ? link : alu_res;  // jumps write the return address

  // jalr clears bit 0 of rs1 plus imm as the isa asks
  assign redirect_valid = pop && (is_jal || is_jalr);
  assign redirect_pc    = is_jal ? head_entry.pc + imm : {alu_res[rv_pkg::xlen-1:1], 1'b0};

  // the write lands on the pop edge so the next pop already sees it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (pop && reg_wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      commit_valid <= 1'b0;
      store_valid  <= 1'b0;
      halted       <= 1'b0;
      illegal      <= 1'b0;
    end else begin
      commit_valid <= pop;  // one retire per popped entry, illegal ones too
      store_valid  <= pop && is_store;
      if (pop && (is_ebreak || inst_not_impl))
        halted <= 1'b1;  // sticky until the next reset
      if (pop && inst_not_impl)
        illegal <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      commit_pc      <= head_entry.pc;
      commit_reg_wen <= reg_wen;
      commit_rd      <= rd;
      commit_wdata   <= wdata;
      store_addr     <= alu_res;  // rs1 plus the s immediate
      store_data     <= rs2_val;
      store_wmask    <= 8'hff;  // sd writes all eight bytes
    end
  end

endmodule

`default_nettype wire

// File: rtl/inst_fetch.sv
/* fetch unit that runs wishbone classic read cycles at the program counter
   and pushes each returned word with its pc into the instruction queue */
`default_nettype none
`timescale 1ns/1ps

module inst_fetch (
  input  logic                             clk,
  input  logic                             rst_n,
  output logic                             wb_cyc,
  output logic                             wb_stb,
  output logic [rv_pkg::xlen-1:0]          wb_adr,
  input  logic [rv_pkg::inst_width-1:0]    wb_dat_rd,
  input  logic                             wb_ack,
  input  logic [rv_pkg::count_width-1:0]   count,
  output logic                             push,
  output rv_pkg::queue_entry_t             push_entry,
  input  logic                             redirect_valid,
  input  logic [rv_pkg::xlen-1:0]          redirect_pc
);

  logic [rv_pkg::xlen-1:0] pc;  // address of the next word to request
  logic [rv_pkg::xlen-1:0] next_pc;
  logic                    busy;     // a bus cycle is open
  logic                    discard;  // the open cycle was overtaken by a redirect
  logic                    start;

  // a redirect in an idle cycle is taken by the request that starts there
  assign next_pc = redirect_valid ? redirect_pc : pc;

  // one free slot is needed for the word that the new request brings back
  assign start = !busy && (count < rv_pkg::queue_depth);

  assign wb_cyc = busy;
  assign wb_stb = busy;

  // a stale word still finishes its bus cycle but never reaches the queue
  assign push            = busy && wb_ack && !discard;
  assign push_entry.pc   = wb_adr;
  assign push_entry.inst = wb_dat_rd;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      discard <= 1'b0;
      pc      <= rv_pkg::reset_pc;
    end else begin
      if (busy) begin
        if (wb_ack) begin
          busy    <= 1'b0;  // cyc and stb drop in the cycle after the ack
          discard <= 1'b0;
        end else if (redirect_valid) begin
          discard <= 1'b1;
        end
      end else if (start) begin
        busy <= 1'b1;
      end
      if (redirect_valid)
        pc <= redirect_pc;
      else if (push)
        pc <= pc + 'd4;  // sequential fetch after an accepted word
    end
  end

  // the address is latched once per request and held until the ack
  always_ff @(posedge clk) begin
    if (start)
      wb_adr <= next_pc;
  end

endmodule

`default_nettype wire

// File: rtl/inst_queue.sv
/* small synchronous fifo of pc and instruction entries between fetch and
   execute, with a flush that drops everything on a taken jump */
`default_nettype none
`timescale 1ns/1ps

module inst_queue (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           push,
  input  rv_pkg::queue_entry_t           push_entry,
  input  logic                           pop,
  input  logic                           flush,
  output rv_pkg::queue_entry_t           head_entry,
  output logic                           empty,
  output logic                           full,
  output logic [rv_pkg::count_width-1:0] count
);

  rv_pkg::queue_entry_t mem [rv_pkg::queue_depth];

  logic [rv_pkg::ptr_width-1:0] rd_ptr;
  logic [rv_pkg::ptr_width-1:0] wr_ptr;

  assign head_entry = mem[rd_ptr];  // visible the cycle after its push
  assign empty      = (count == '0);
  assign full       = (count == rv_pkg::queue_depth);

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      rd_ptr <= '0;  // flush beats a push on the same edge
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps since the depth is a power of two
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither leave the level alone
      endcase
    end
  end

  // storage carries payload only
  always_ff @(posedge clk) begin
    if (push && !flush)
      mem[wr_ptr] <= push_entry;
  end

endmodule

`default_nettype wire

// File: rtl/rv_pkg.sv
/* shared widths, reset pc, queue sizing, alu operation codes and the queue
   entry type for the rv64 front slice, referenced by scoped names */
`default_nettype none

package rv_pkg;

  localparam int xlen         = 64;  // register and data width
  localparam int inst_width   = 32;
  localparam int reg_id_width = 5;

  localparam logic [xlen-1:0] reset_pc = '0;  // first fetch address

  // queue depth must stay a power of two so the pointers wrap on their own
  localparam int queue_depth = 4;
  localparam int ptr_width   = $clog2(queue_depth);
  localparam int count_width = $clog2(queue_depth) + 1;  // holds 0 up to queue_depth

  // operation picked by the decoder for the single alu in the execute unit
  typedef enum logic [1:0] {
    alu_add  = 2'd0,  // a + b
    alu_sub  = 2'd1,  // a - b
    alu_lt   = 2'd2,  // signed a < b as 0 or 1
    alu_none = 2'd3   // result forced to zero
  } alu_op_t;

  // one fetched word together with the address it came from
  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [inst_width-1:0] inst;
  } queue_entry_t;

endpackage

`default_nettype wire

// File: rtl/rvcore_lite_top.sv
/* top level of the rv64 front slice, wiring fetch, queue and execute
   to the wishbone instruction port and the commit and store outputs */
`default_nettype none
`timescale 1ns/1ps

module rvcore_lite_top (
  input  logic                            clk,
  input  logic                            rst_n,
  output logic                            wb_cyc,
  output logic                            wb_stb,
  output logic [rv_pkg::xlen-1:0]         wb_adr,
  input  logic [rv_pkg::inst_width-1:0]   wb_dat_rd,
  input  logic                            wb_ack,
  output logic                            commit_valid,
  output logic [rv_pkg::xlen-1:0]         commit_pc,
  output logic                            commit_reg_wen,
  output logic [rv_pkg::reg_id_width-1:0] commit_rd,
  output logic [rv_pkg::xlen-1:0]         commit_wdata,
  output logic                            store_valid,
  output logic [rv_pkg::xlen-1:0]         store_addr,
  output logic [rv_pkg::xlen-1:0]         store_data,
  output logic [7:0]                      store_wmask,
  output logic                            halted,
  output logic                            illegal
);

  logic                           push, pop, empty;
  logic                           redirect_valid;
  logic [rv_pkg::xlen-1:0]        redirect_pc;
  logic [rv_pkg::count_width-1:0] count;
  rv_pkg::queue_entry_t           push_entry, head_entry;

  inst_fetch i_fetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_adr         (wb_adr),
    .wb_dat_rd      (wb_dat_rd),
    .wb_ack         (wb_ack),
    .count          (count),
    .push           (push),
    .push_entry     (push_entry),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  // fetch throttles on count, so the full flag has no reader here
  inst_queue i_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (push),
    .push_entry (push_entry),
    .pop        (pop),
    .flush      (redirect_valid),  // a taken jump empties the queue
    .head_entry (head_entry),
    .empty      (empty),
    .full       (),
    .count      (count)
  );

  exec_unit i_exec (
    .clk            (clk),
    .rst_n          (rst_n),
    .head_entry     (head_entry),
    .empty          (empty),
    .pop            (pop),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_reg_wen (commit_reg_wen),
    .commit_rd      (commit_rd),
    .commit_wdata   (commit_wdata),
    .store_valid    (store_valid),
    .store_addr     (store_addr),
    .store_data     (store_data),
    .store_wmask    (store_wmask),
    .halted         (halted),
    .illegal        (illegal)
  );

endmodule

`default_nettype wire

// File: rvcore_lite.f
+incdir+include
rtl/rv_pkg.sv
rtl/inst_fetch.sv
rtl/inst_queue.sv
rtl/decoder.sv
rtl/exec_unit.sv
rtl/rvcore_lite_top.sv
test/tb_inst_mem.sv
test/tb_rvcore_lite.sv

// File: test/tb_inst_mem.sv
/* wishbone classic slave instruction memory for the testbench, answering
   each read after 0 to 3 random wait states, loaded by the testbench top */
`default_nettype none
`timescale 1ns/1ps

module tb_inst_mem (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic [63:0] wb_adr,
  output logic [31:0] wb_dat_rd,
  output logic        wb_ack
);

  logic [31:0] mem [64];  // word array, the testbench writes it before each run
  logic [31:0] rng = 32'hbd04;  // runs on across resets so each program sees new waits
  logic        armed;  // a request has been seen and its wait drawn
  logic [1:0]  wait_left;

  // full period lcg, the upper bits are the useful ones
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    wb_ack    = 1'b0;
    wb_dat_rd = '0;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
      armed  <= 1'b0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;  // exactly one ack cycle per request
    end else if (wb_cyc && wb_stb) begin
      if (!armed) begin
        armed     <= 1'b1;
        rng       <= lcg_next(rng);
        wait_left <= 2'(lcg_next(rng) >> 16);
      end else if (wait_left != 2'd0) begin
        wait_left <= wait_left - 2'd1;
      end else begin
        wb_ack    <= 1'b1;
        wb_dat_rd <= mem[wb_adr[7:2]];  // the master holds the address until the ack
        armed     <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: test/tb_rvcore_lite.sv
/* testbench top for the rv64 front slice: assembles two programs, runs them
   from reset against an isa reference model and checks commits, stores,
   halt and the wishbone handshake with concurrent assertions */
`default_nettype none
`timescale 1ns/1ps

`include "rv_opcodes.svh"

module tb_rvcore_lite;

  logic        clk, rst_n, wb_cyc, wb_stb, wb_ack, halted, illegal;
  logic [63:0] wb_adr, commit_pc, commit_wdata, store_addr, store_data;
  logic [31:0] wb_dat_rd;
  logic        commit_valid, commit_reg_wen, store_valid;
  logic [4:0]  commit_rd;
  logic [7:0]  store_wmask;

  logic [31:0] prog [64];  // program image, copied into the memory model
  logic [63:0] rf [32];  // reference register file
  logic [63:0] model_pc, exp_wdata, exp_next, exp_saddr, exp_sdata;
  logic [4:0]  exp_rd;
  logic        exp_wen, exp_store, exp_halt, exp_illegal, model_done;
  int          n_commits, cycles, run_start, limit;

  rvcore_lite_top i_dut (.*);

  tb_inst_mem i_mem (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                         input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input int rd,
                                         input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], `f3_add_sub, rd[4:0], `op_op};
  endfunction

  function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], `f3_double, imm[4:0], `op_store};
  endfunction

  function automatic logic [31:0] u_type(input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], `op_auipc};
  endfunction

  function automatic logic [31:0] j_type(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `op_jal};
  endfunction

  // unused words get an unknown opcode that still varies with the address
  task automatic fill_program();
    for (int i = 0; i < 64; i++)
      prog[i] = {16'hc0de ^ 16'(i), 16'h007f};
  endtask

  // isa level prediction for the instruction at model_pc
  always_comb begin : predict
    logic [31:0] w;
    logic [63:0] a, b, imm_i, imm_s, imm_j;
    w     = prog[model_pc[7:2]];
    a     = rf[w[`rs1_bits]];  // rf[0] never leaves zero
    b     = rf[w[`rs2_bits]];
    imm_i = {{52{w[31]}}, w[31:20]};
    imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
    imm_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    exp_rd = w[`rd_bits];
    {exp_wen, exp_store, exp_halt, exp_illegal} = 4'b0;
    {exp_wdata, exp_saddr, exp_sdata} = '0;
    exp_next = model_pc + 64'd4;
    case (w[`opcode_bits])
      `op_imm: begin
        exp_wen = 1'b1;
        if (w[`funct3_bits] == `f3_add_sub)
          exp_wdata = a + imm_i;
        else if (w[`funct3_bits] == `f3_slt)
          exp_wdata = {63'd0, $signed(a) < $signed(imm_i)};
        else
          exp_illegal = 1'b1;
      end
      `op_op: begin
        exp_wen = 1'b1;
        if (w[`funct3_bits] == `f3_add_sub && w[`funct7_bits] == `f7_base)
          exp_wdata = a + b;
        else if (w[`funct3_bits] == `f3_add_sub && w[`funct7_bits] == `f7_alt)
          exp_wdata = a - b;
        else
          exp_illegal = 1'b1;
      end
      `op_auipc: begin
        exp_wen   = 1'b1;
        exp_wdata = model_pc + {{32{w[31]}}, w[31:12], 12'd0};
      end
      `op_jal: begin
        exp_wen   = 1'b1;
        exp_wdata = model_pc + 64'd4;  // link value
        exp_next  = model_pc + imm_j;
      end
      `op_jalr: begin
        exp_wen     = (w[`funct3_bits] == `f3_jalr);
        exp_illegal = !exp_wen;
        exp_wdata   = model_pc + 64'd4;
        exp_next    = (a + imm_i) & ~64'd1;
      end
      `op_store: begin
        exp_store   = (w[`funct3_bits] == `f3_double);
        exp_illegal = !exp_store;
        exp_saddr   = a + imm_s;
        exp_sdata   = b;
      end
      `op_system: begin
        exp_halt    = (w[`funct3_bits] == `f3_priv) && (w[`funct12_bits] == `f12_ebreak);
        exp_illegal = !exp_halt;
      end
      default: exp_illegal = (w != 32'd0);  // ld lands here, the zero word is a nop
    endcase
    if (exp_illegal)
      exp_wen = 1'b0;  // an illegal word retires without a write
    exp_halt = exp_halt || exp_illegal;
  end

  // the model advances once per commit
  always @(posedge clk) begin
    if (!rst_n) begin
      model_pc   <= 64'd0;
      model_done <= 1'b0;
      n_commits  <= 0;
      for (int i = 0; i < 32; i++)
        rf[i] <= '0;
    end else if (commit_valid) begin
      if (exp_wen && exp_rd != 5'd0)
        rf[exp_rd] <= exp_wdata;
      model_pc   <= exp_next;
      model_done <= model_done || exp_halt;
      n_commits  <= n_commits + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles - run_start > limit)
      stop_with_failure($sformatf("timeout: the program did not halt within %0d cycles", limit));
  end

  a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
    !wb_cyc && !wb_stb && !commit_valid && !store_valid && !halted && !illegal)
    else stop_with_failure($sformatf("[FAIL] %0t: outputs not idle after reset", $time));

  a_commit_pc: assert property (@(posedge clk) disable iff (!rst_n)
    commit_valid |-> commit_pc == model_pc)
    else stop_with_failure($sformatf("[FAIL] %0t: commit pc %h, model expects %h",
                                     $time, $sampled(commit_pc), $sampled(model_pc)));

  a_commit_wen: assert property (@(posedge clk) disable iff (!rst_n)
    commit_valid |-> commit_reg_wen == exp_wen)
    else stop_with_failure($sformatf("[FAIL] %0t: wrong commit_reg_wen", $time));

  a_commit_data: assert property (@(posedge clk) disable iff (!rst_n)
    commit_valid && exp_wen |-> commit_rd == exp_rd && commit_wdata == exp_wdata)
    else stop_with_failure($sformatf("[FAIL] %0t: x%0d written %h, model expects %h",
                                     $time, $sampled(commit_rd), $sampled(commit_wdata),
                                     $sampled(exp_wdata)));

  a_store_valid: assert property (@(posedge clk) disable iff (!rst_n)
    (commit_valid |-> store_valid == exp_store) and (store_valid |-> commit_valid))
    else stop_with_failure($sformatf("[FAIL] %0t: store_valid out of step", $time));

  a_store_fields: assert property (@(posedge clk) disable iff (!rst_n)
    store_valid |-> store_addr == exp_saddr && store_data == exp_sdata &&
                    store_wmask == 8'hff)
    else stop_with_failure($sformatf("[FAIL] %0t: store addr %h data %h mask %h wrong",
                                     $time, $sampled(store_addr), $sampled(store_data),
                                     $sampled(store_wmask)));

  a_halt_flags: assert property (@(posedge clk) disable iff (!rst_n)
    commit_valid |-> halted == exp_halt && illegal == exp_illegal)
    else stop_with_failure($sformatf("[FAIL] %0t: halted or illegal wrong at commit", $time));

  a_no_commit_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
    model_done |-> !commit_valid && halted)
    else stop_with_failure($sformatf("[FAIL] %0t: commit after the halt", $time));

  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
    else stop_with_failure($sformatf("[FAIL] %0t: wb_stb without wb_cyc", $time));

  a_stb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
    else stop_with_failure($sformatf("[FAIL] %0t: request dropped or moved before ack", $time));

  a_drop_after_ack: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_stb)
    else stop_with_failure($sformatf("[FAIL] %0t: wb_stb still high after ack", $time));

  // reset, load the image, run to the halt and count the retires
  task automatic run_program(input int n_words, input int n_expected);
    @(posedge clk);
    rst_n <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < 64; i++)
      i_mem.mem[i] = prog[i];
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    run_start = cycles;
    limit     = 40 * n_words * 4;  // worst case of four wait states per word
    while (!halted)
      @(negedge clk);
    repeat (20) @(negedge clk);  // quiet window for stray commits
    if (n_commits != n_expected)
      stop_with_failure($sformatf("[FAIL] %0t: %0d commits, expected %0d",
                                  $time, n_commits, n_expected));
  endtask

  initial begin
    rst_n     = 1'b0;
    cycles    = 0;
    run_start = 0;
    limit     = 1000;
    fill_program();
    prog[0]  = i_type(`op_imm, `f3_add_sub, 1, 0, 5);
    prog[1]  = i_type(`op_imm, `f3_add_sub, 2, 0, -3);
    prog[2]  = i_type(`op_imm, `f3_slt, 3, 2, 1);
    prog[3]  = r_type(`f7_base, 4, 1, 2);
    prog[4]  = r_type(`f7_alt, 5, 2, 1);
    prog[5]  = i_type(`op_imm, `f3_add_sub, 0, 1, 7);  // result thrown away by x0
    prog[6]  = r_type(`f7_base, 6, 0, 1);
    prog[7]  = u_type(7, 1);
    prog[8]  = j_type(8, 12);  // skips two wrong path words
    prog[9]  = i_type(`op_imm, `f3_add_sub, 9, 0, 99);
    prog[10] = i_type(`op_imm, `f3_add_sub, 9, 0, 98);
    prog[11] = i_type(`op_imm, `f3_add_sub, 10, 0, 64);
    prog[12] = i_type(`op_jalr, `f3_jalr, 11, 10, 5);  // odd target, bit 0 cleared
    prog[13] = i_type(`op_imm, `f3_add_sub, 12, 0, 1);
    prog[17] = s_type(5, 1, 8);
    prog[18] = 32'd0;
    prog[19] = i_type(`op_imm, `f3_slt, 13, 1, -1);
    prog[20] = {`f12_ebreak, 5'd0, `f3_priv, 5'd0, `op_system};
    run_program(21, 15);
    fill_program();
    prog[0] = i_type(`op_imm, `f3_add_sub, 1, 0, 16);
    prog[1] = r_type(`f7_base, 2, 1, 1);
    prog[2] = i_type(`op_load, `f3_double, 3, 1, 0);  // ld has no data port here
    prog[3] = i_type(`op_imm, `f3_add_sub, 4, 0, 1);
    run_program(4, 3);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
